// File: Makefile
# Verilator build and run for the AXI memory subsystem

SIM = obj_dir/axi_mem_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module axi_mem_tb \
		-f axi_mem_sys.f -o axi_mem_sim

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: axi_mem_sys.f
src/axi_mem_pkg.sv
src/mem_req_queue.sv
src/axi_adapter.sv
src/axi_ram.sv
src/axi_mem_top.sv
test/axi_mem_tb.sv

// File: src/axi_adapter.sv
`timescale 1ns/1ps

module axi_adapter import axi_mem_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    // Core request
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,

    // Core response
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp,

    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_aw_t  aw,

    output logic     w_valid,
    input  logic     w_ready,
    output axi_w_t   w,

    input  logic     b_valid,
    output logic     b_ready,
    input  axi_b_t   b,

    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_ar_t  ar,

    input  logic     r_valid,
    output logic     r_ready,
    input  axi_r_t   r,

    output logic     resp_error
);

    logic                      aw_ack;
    logic                      w_ack;
    logic                      req_fire;
    logic                      write_ready;
    logic [AXI_ADDR_WIDTH-1:0] byte_addr;

    assign req_fire = req_valid && req_ready;

    // AW and W may complete in different cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            aw_ack <= 1'b0;
            w_ack  <= 1'b0;
        end else if (req_fire) begin
            aw_ack <= 1'b0;
            w_ack  <= 1'b0;
        end else begin
            aw_ack <= aw_ack || (aw_valid && aw_ready);
            w_ack  <= w_ack || (w_valid && w_ready);
        end
    end

    assign write_ready = (aw_ready || aw_ack) && (w_ready || w_ack);
    assign req_ready   = req.rw ? write_ready : ar_ready;

    assign byte_addr = AXI_ADDR_WIDTH'(req.addr) << AXSIZE;

    assign aw_valid = req_valid && req.rw && !aw_ack;
    always_comb begin
        aw       = '0;
        aw.id    = req.tag;
        aw.addr  = byte_addr;
        aw.size  = 3'(AXSIZE);
    end

    assign w_valid = req_valid && req.rw && !w_ack;
    assign w.data  = req.data;
    assign w.strb  = req.byteen;
    assign w.last  = 1'b1;

    // Writes are done on acceptance, B only feeds the error flag
    assign b_ready = 1'b1;

    assign ar_valid = req_valid && !req.rw;
    always_comb begin
        ar       = '0;
        ar.id    = req.tag;
        ar.addr  = byte_addr;
        ar.size  = 3'(AXSIZE);
    end

    assign rsp_valid = r_valid;
    assign rsp.data  = r.data;
    assign rsp.tag   = r.id;
    assign r_ready   = rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_error <= 1'b0;
        end else if ((b_valid && b_ready && b.resp != RESP_OKAY) ||
                     (r_valid && r_ready && r.resp != RESP_OKAY)) begin
            resp_error <= 1'b1;
        end
    end

endmodule

// File: src/axi_mem_pkg.sv
package axi_mem_pkg;

    localparam int DATA_WIDTH      = 64;
    localparam int BYTEEN_WIDTH    = DATA_WIDTH / 8;
    localparam int AXSIZE          = $clog2(BYTEEN_WIDTH);
    localparam int ADDR_WIDTH      = 32 - AXSIZE;
    localparam int AXI_ADDR_WIDTH  = 32;
    localparam int TAG_WIDTH       = 8;
    localparam int RAM_WORDS       = 256;
    localparam int RAM_INDEX_WIDTH = $clog2(RAM_WORDS);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Core side
    typedef struct packed {
        logic                    rw;
        logic [BYTEEN_WIDTH-1:0] byteen;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0]  tag;
    } mem_rsp_t;

    // AXI4 channel payloads
    typedef struct packed {
        logic [TAG_WIDTH-1:0]      id;
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      lock;
        logic [3:0]                cache;
        logic [2:0]                prot;
        logic [3:0]                qos;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [BYTEEN_WIDTH-1:0] strb;
        logic                    last;
    } axi_w_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0] id;
        logic [1:0]           resp;
    } axi_b_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

endpackage

// File: src/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top import axi_mem_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,

    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp,

    output logic     resp_error
);

    logic     q_valid;
    logic     q_ready;
    mem_req_t q_req;

    logic    aw_valid, aw_ready;
    logic    w_valid, w_ready;
    logic    b_valid, b_ready;
    logic    ar_valid, ar_ready;
    logic    r_valid, r_ready;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    axi_ar_t ar;
    axi_r_t  r;

    mem_req_queue queue_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in        (req),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out       (q_req)
    );

    axi_adapter adapter_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (q_valid),
        .req_ready  (q_ready),
        .req        (q_req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b          (b),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r),
        .resp_error (resp_error)
    );

    axi_ram ram_i (
        .clk      (clk),
        .reset    (reset),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

endmodule

// File: src/axi_ram.sv
`timescale 1ns/1ps

module axi_ram import axi_mem_pkg::*; (
    input  logic    clk,
    input  logic    reset,

    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_aw_t aw,

    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,

    output logic    b_valid,
    input  logic    b_ready,
    output axi_b_t  b,

    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ar_t ar,

    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r
);

    localparam int WORD_WIDTH = AXI_ADDR_WIDTH - AXSIZE;

    logic [DATA_WIDTH-1:0] mem [RAM_WORDS];

    axi_aw_t aw_q;
    axi_w_t  w_q;
    logic    aw_full;
    logic    w_full;

    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic write_fire;

    logic [WORD_WIDTH-1:0]      wr_word;
    logic [WORD_WIDTH-1:0]      rd_word;
    logic [RAM_INDEX_WIDTH-1:0] wr_index;
    logic [RAM_INDEX_WIDTH-1:0] rd_index;
    logic                       wr_in_range;
    logic                       rd_in_range;

    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;

    // Hold off reads while a write is still parked, so reads see it
    assign ar_ready = !r_valid && !aw_full && !w_full;

    assign aw_fire    = aw_valid && aw_ready;
    assign w_fire     = w_valid && w_ready;
    assign ar_fire    = ar_valid && ar_ready;
    assign write_fire = aw_full && w_full && !b_valid;

    assign wr_word     = aw_q.addr[AXI_ADDR_WIDTH-1:AXSIZE];
    assign rd_word     = ar.addr[AXI_ADDR_WIDTH-1:AXSIZE];
    assign wr_index    = wr_word[RAM_INDEX_WIDTH-1:0];
    assign rd_index    = rd_word[RAM_INDEX_WIDTH-1:0];
    assign wr_in_range = (wr_word < WORD_WIDTH'(RAM_WORDS));
    assign rd_in_range = (rd_word < WORD_WIDTH'(RAM_WORDS));

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_full <= 1'b1;
            end else if (write_fire) begin
                aw_full <= 1'b0;
            end

            if (w_fire) begin
                w_full <= 1'b1;
            end else if (write_fire) begin
                w_full <= 1'b0;
            end

            if (write_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end

            if (ar_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_q <= aw;
        end
        if (w_fire) begin
            w_q <= w;
        end
    end

    // Byte-strobed write
    always_ff @(posedge clk) begin
        if (write_fire && wr_in_range) begin
            for (int i = 0; i < BYTEEN_WIDTH; i++) begin
                if (w_q.strb[i]) begin
                    mem[wr_index][8*i +: 8] <= w_q.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            b.id   <= aw_q.id;
            b.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Out of range reads give zero data
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r.id   <= ar.id;
            r.data <= rd_in_range ? mem[rd_index] : '0;
            r.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
            r.last <= 1'b1;
        end
    end

endmodule

// File: src/mem_req_queue.sv
`timescale 1ns/1ps

module mem_req_queue import axi_mem_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  mem_req_t in,

    output logic     out_valid,
    input  logic     out_ready,
    output mem_req_t out
);

    mem_req_t   entries [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [1:0] count_next;
    logic       push;
    logic       pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 2'd1;
        end else if (pop && !push) begin
            count_next = count - 2'd1;
        end
    end

    // Ready is registered so it stays low through reset
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count    <= count_next;
            in_ready <= (count_next != 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in;
        end
    end

    assign out_valid = (count != 2'd0);
    assign out       = entries[rd_ptr];

endmodule

// File: test/axi_mem_tb.sv
`timescale 1ns/1ps

module axi_mem_tb import axi_mem_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_WORDS    = 16;
    localparam int NUM_MIXED    = 64;
    localparam int DRAIN_LIMIT  = 200;
    localparam int ERROR_WAIT   = 20;
    // Writes and reads of every word in two tests, the mixed stream, three error requests
    localparam int TOTAL_REQS      = 4 * NUM_WORDS + NUM_MIXED + 3;
    localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + TOTAL_REQS * 20 + 1000;

    logic     clk = 1'b0;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_rsp_t rsp;
    logic     resp_error;

    integer               seed        = 32'hc08988f3;
    logic [TAG_WIDTH-1:0] next_tag    = '0;
    logic                 bp_enable   = 1'b0;
    logic                 allow_error = 1'b0;
    int                   error_count = 0;
    int                   pass_count  = 0;
    int                   fail_count  = 0;

    // Reference model state
    logic [DATA_WIDTH-1:0] ref_mem [RAM_WORDS];
    mem_rsp_t              expq [$];
    mem_rsp_t              exp_head;
    int                    exp_count   = 0;
    logic                  reset_d     = 1'b0;
    logic                  held_valid  = 1'b0;
    mem_rsp_t              held_rsp;
    logic                  err_latched = 1'b0;

    axi_mem_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .resp_error (resp_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Tracks accepted requests and the expected read responses in order
    always @(posedge clk) begin : monitor
        mem_rsp_t item;
        logic     in_range;
        reset_d <= reset;
        if (reset) begin
            expq.delete();
            held_valid  <= 1'b0;
            err_latched <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready && expq.size() != 0) begin
                void'(expq.pop_front());
            end
            if (req_valid && req_ready) begin
                in_range = (req.addr < ADDR_WIDTH'(RAM_WORDS));
                if (req.rw && in_range) begin
                    for (int b = 0; b < BYTEEN_WIDTH; b++) begin
                        if (req.byteen[b]) begin
                            ref_mem[req.addr[RAM_INDEX_WIDTH-1:0]][8*b +: 8] = req.data[8*b +: 8];
                        end
                    end
                end else if (!req.rw) begin
                    item.tag  = req.tag;
                    item.data = in_range ? ref_mem[req.addr[RAM_INDEX_WIDTH-1:0]] : '0;
                    expq.push_back(item);
                end
            end
            held_valid  <= rsp_valid && !rsp_ready;
            err_latched <= err_latched || resp_error;
        end
        held_rsp  <= rsp;
        exp_count <= expq.size();
        exp_head  <= (expq.size() != 0) ? expq[0] : '0;
    end

    reset_idle: assert property (@(posedge clk) reset_d |-> !req_ready && !rsp_valid && !resp_error)
        else begin
            $display("Mismatch reset outputs: req_ready=%h rsp_valid=%h resp_error=%h expected 0",
                     $sampled(req_ready), $sampled(rsp_valid), $sampled(resp_error));
            error_count++;
        end

    rsp_expected: assert property (@(posedge clk) disable iff (reset)
                                   rsp_valid && rsp_ready |-> exp_count != 0)
        else begin
            $display("Response with tag %h arrived with no read outstanding", $sampled(rsp.tag));
            error_count++;
        end

    rsp_tag_match: assert property (@(posedge clk) disable iff (reset)
                                    rsp_valid && rsp_ready && exp_count != 0 |->
                                    rsp.tag == exp_head.tag)
        else begin
            $display("Mismatch rsp.tag: got %h expected %h",
                     $sampled(rsp.tag), $sampled(exp_head.tag));
            error_count++;
        end

    rsp_data_match: assert property (@(posedge clk) disable iff (reset)
                                     rsp_valid && rsp_ready && exp_count != 0 |->
                                     rsp.data == exp_head.data)
        else begin
            $display("Mismatch rsp.data: got %h expected %h",
                     $sampled(rsp.data), $sampled(exp_head.data));
            error_count++;
        end

    rsp_hold_valid: assert property (@(posedge clk) disable iff (reset) held_valid |-> rsp_valid)
        else begin
            $display("rsp_valid dropped while rsp_ready was low");
            error_count++;
        end

    rsp_hold_payload: assert property (@(posedge clk) disable iff (reset)
                                       held_valid && rsp_valid |-> rsp == held_rsp)
        else begin
            $display("Mismatch rsp while stalled: got %h expected %h",
                     $sampled(rsp), $sampled(held_rsp));
            error_count++;
        end

    error_low: assert property (@(posedge clk) disable iff (reset) !allow_error |-> !resp_error)
        else begin
            $display("Mismatch resp_error: got %h expected 0", $sampled(resp_error));
            error_count++;
        end

    error_sticky: assert property (@(posedge clk) disable iff (reset) err_latched |-> resp_error)
        else begin
            $display("resp_error cleared after it had been set");
            error_count++;
        end

    task automatic drive_rsp_ready();
        logic [31:0] rnd;
        if (bp_enable) begin
            rnd       = $random(seed);
            rsp_ready = rnd[0];
        end else begin
            rsp_ready = 1'b1;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
        drive_rsp_ready();
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // Scattered word addresses, all distinct below RAM_WORDS
    function automatic logic [ADDR_WIDTH-1:0] word_addr(input int i);
        return ADDR_WIDTH'((i * 37 + 3) % RAM_WORDS);
    endfunction

    task automatic send_request(input logic rw, input logic [BYTEEN_WIDTH-1:0] byteen,
                                input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] data);
        logic accepted;
        req_valid  = 1'b1;
        req.rw     = rw;
        req.byteen = byteen;
        req.addr   = addr;
        req.data   = data;
        req.tag    = next_tag;
        next_tag   = next_tag + TAG_WIDTH'(1);
        accepted   = 1'b0;
        // req_ready is registered, so its value here holds for the coming edge
        while (!accepted) begin
            accepted = req_ready;
            step();
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_count != 0 && cycles < DRAIN_LIMIT) begin
            step();
            cycles++;
        end
        assert (exp_count == 0) else begin
            $display("Read responses missing: %0d still outstanding after %0d cycles",
                     exp_count, cycles);
            error_count++;
        end
    endtask

    task automatic wait_for_error(input string cause);
        int cycles;
        cycles = 0;
        while (!resp_error && cycles < ERROR_WAIT) begin
            step();
            cycles++;
        end
        assert (resp_error) else begin
            $display("resp_error did not rise after an out of range %s", cause);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic reset_state_test();
        int errors_before;
        errors_before = error_count;
        apply_reset();
        step();
        step();
        report_test("reset state", errors_before);
    endtask

    task automatic round_trip_test();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < NUM_WORDS; i++) begin
            send_request(1'b1, '1, word_addr(i), random_word());
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            send_request(1'b0, '0, word_addr(i), '0);
        end
        wait_for_drain();
        report_test("full word round trip", errors_before);
    endtask

    task automatic byteen_test();
        int          errors_before;
        logic [31:0] rnd;
        errors_before = error_count;
        for (int i = 0; i < NUM_WORDS; i++) begin
            rnd = $random(seed);
            send_request(1'b1, rnd[BYTEEN_WIDTH-1:0], word_addr(i), random_word());
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            send_request(1'b0, '0, word_addr(i), '0);
        end
        wait_for_drain();
        report_test("byte enables", errors_before);
    endtask

    task automatic ordering_test();
        int          errors_before;
        int          idx;
        logic [31:0] rnd;
        errors_before = error_count;
        bp_enable     = 1'b1;
        for (int i = 0; i < NUM_MIXED; i++) begin
            rnd = $random(seed);
            idx = rnd % NUM_WORDS;
            if (rnd[8]) begin
                send_request(1'b1, rnd[23:16], word_addr(idx), random_word());
            end else begin
                send_request(1'b0, '0, word_addr(idx), '0);
            end
        end
        wait_for_drain();
        bp_enable = 1'b0;
        step();
        report_test("ordering under back-pressure", errors_before);
    endtask

    task automatic error_flag_test();
        int errors_before;
        errors_before = error_count;
        allow_error   = 1'b1;
        // Out of range write aliases word 0 if the range check fails
        send_request(1'b1, '1, ADDR_WIDTH'(RAM_WORDS) + word_addr(0), random_word());
        wait_for_error("write");
        send_request(1'b0, '0, word_addr(0), '0);
        wait_for_drain();
        // Flag cleared again so the read path has to raise it alone
        apply_reset();
        send_request(1'b0, '0, ADDR_WIDTH'(RAM_WORDS) + word_addr(1), '0);
        wait_for_error("read");
        wait_for_drain();
        repeat (4) step();
        report_test("error flag", errors_before);
    endtask

    initial begin : main
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        reset_state_test();
        round_trip_test();
        byteen_test();
        ordering_test();
        error_flag_test();
        $display("Summary: passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule
